//--- verilog/usb_xact_pkg.sv
package usb_xact_pkg;

  // Token kinds as delivered by the packet decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  // Handshake kinds, upper PID bits only
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_t;

  // Data packet kinds toward the encoder
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_t;

  // Transfer and reject codes
  // Gaps in the encoding are kept for compatibility
  typedef enum logic [2:0] {
    ERR_NONE    = 3'h0,
    ERR_BLK_IN  = 3'h1,
    ERR_BLK_OUT = 3'h2,
    ERR_TOKEN   = 3'h3,
    ERR_ENDP    = 3'h5
  } err_code_t;

  // Top transaction FSM
  typedef enum logic [1:0] {
    XFER_IDLE = 2'd0,
    XFER_BULK = 2'd1,
    XFER_DUMP = 2'd2
  } xfer_state_t;

  // Bulk stage FSM
  typedef enum logic [2:0] {
    BULK_IDLE     = 3'd0,
    BULK_DATI_TX  = 3'd1,
    BULK_DATI_ZDP = 3'd2,
    BULK_DATI_ACK = 3'd3,
    BULK_DATO_RX  = 3'd4,
    BULK_DATO_ERR = 3'd5,
    BULK_DATO_HSK = 3'd6,
    BULK_DONE     = 3'd7
  } bulk_state_t;

endpackage

//--- verilog/token_dispatch.sv
`timescale 1ns/1ps
module token_dispatch
  import usb_xact_pkg::*;
#(
  parameter logic [3:0] BULK_ENDPOINT = 4'd1
) (
  input  logic       clock,
  input  logic       reset,
  input  logic [6:0] usb_addr_i,
  input  logic       tok_recv_i,
  input  tok_type_t  tok_type_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  logic       bulk_done_i,
  output logic       bulk_go_o,
  output logic       bulk_dir_in_o,
  output logic [3:0] xfer_endp_o,
  output logic       blk_cycle_o,
  output logic       xfer_error_o,
  output err_code_t  err_code_o
);

  xfer_state_t state_q;

  // Token for this device
  logic tok_match;
  // IN or OUT, the only kinds a bulk endpoint takes
  logic tok_data;

  assign tok_match = tok_recv_i && (tok_addr_i == usb_addr_i);
  assign tok_data  = (tok_type_i == TOK_IN) || (tok_type_i == TOK_OUT);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= XFER_IDLE;
      bulk_go_o    <= 1'b0;
      blk_cycle_o  <= 1'b0;
      xfer_error_o <= 1'b0;
      err_code_o   <= ERR_NONE;
    end else begin
      // Start pulse lasts a single cycle
      bulk_go_o    <= 1'b0;
      // Error strobe follows one cycle in DUMP
      xfer_error_o <= (state_q == XFER_DUMP);
      // Cycle flag opens after the start pulse
      if (bulk_go_o) begin
        blk_cycle_o <= 1'b1;
      end else if (bulk_done_i) begin
        blk_cycle_o <= 1'b0;
      end
      case (state_q)
        XFER_IDLE: begin
          if (tok_match) begin
            if (tok_data && tok_endp_i == BULK_ENDPOINT) begin
              state_q    <= XFER_BULK;
              bulk_go_o  <= 1'b1;
              err_code_o <= (tok_type_i == TOK_IN) ? ERR_BLK_IN : ERR_BLK_OUT;
            end else begin
              // Wrong endpoint, or SETUP and SOF
              state_q    <= XFER_DUMP;
              err_code_o <= tok_data ? ERR_ENDP : ERR_TOKEN;
            end
          end
        end
        XFER_BULK: begin
          // Hold until the sequencer finishes
          if (bulk_done_i) begin
            state_q <= XFER_IDLE;
          end
        end
        default: begin
          // Rejected token, back to idle
          state_q <= XFER_IDLE;
        end
      endcase
    end
  end

  // Endpoint and direction of the accepted token
  always_ff @(posedge clock) begin
    if (reset) begin
      xfer_endp_o   <= '0;
      bulk_dir_in_o <= 1'b0;
    end else if (state_q == XFER_IDLE && tok_match) begin
      xfer_endp_o   <= tok_endp_i;
      bulk_dir_in_o <= (tok_type_i == TOK_IN);
    end
  end

endmodule

//--- verilog/bulk_sequencer.sv
`timescale 1ns/1ps
module bulk_sequencer
  import usb_xact_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      bulk_go_i,
  input  logic      bulk_dir_in_i,
  input  logic      blk_in_ready_i,
  input  logic      blk_out_ready_i,
  input  logic      usb_sent_i,
  input  logic      hsk_recv_i,
  input  hsk_type_t hsk_type_i,
  input  logic      hsk_sent_i,
  input  logic      zdp_accepted_i,
  input  logic      usb_tvalid_i,
  input  logic      usb_tlast_i,
  input  logic      blk_tready_i,
  output logic      bulk_done_o,
  output logic      blk_start_o,
  output logic      usb_tready_o,
  output logic      blk_tvalid_o,
  output logic      in_sel_o,
  output logic      zdp_req_o,
  output logic      out_phase_o,
  output logic      out_nak_o,
  output logic      toggle_out_o,
  output logic      toggle_in_o
);

  bulk_state_t state_q;
  bulk_state_t state_d;

  // Encoder has taken the zero-data beat
  logic zdp_taken_q;
  // Last OUT beat moved this cycle
  logic out_last;

  assign out_last = usb_tvalid_i && usb_tready_o && usb_tlast_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      BULK_IDLE: begin
        if (bulk_go_i && bulk_dir_in_i) begin
          state_d = blk_in_ready_i ? BULK_DATI_TX : BULK_DATI_ZDP;
        end else if (bulk_go_i) begin
          state_d = blk_out_ready_i ? BULK_DATO_RX : BULK_DATO_ERR;
        end
      end
      BULK_DATI_TX: begin
        if (usb_sent_i) begin
          state_d = BULK_DATI_ACK;
        end
      end
      BULK_DATI_ZDP: begin
        // Only once the beat has left the mux
        if (usb_sent_i && (zdp_taken_q || zdp_accepted_i)) begin
          state_d = BULK_DATI_ACK;
        end
      end
      BULK_DATI_ACK: begin
        if (hsk_recv_i) begin
          state_d = BULK_DONE;
        end
      end
      BULK_DATO_RX, BULK_DATO_ERR: begin
        if (out_last) begin
          state_d = BULK_DATO_HSK;
        end
      end
      BULK_DATO_HSK: begin
        if (hsk_sent_i) begin
          state_d = BULK_DONE;
        end
      end
      default: begin
        state_d = BULK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= BULK_IDLE;
      blk_start_o <= 1'b0;
      out_nak_o   <= 1'b0;
      zdp_taken_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      blk_start_o <= (state_q == BULK_IDLE) && bulk_go_i;
      // NAK when the endpoint cannot take OUT data
      if (state_q == BULK_IDLE && bulk_go_i) begin
        out_nak_o <= !bulk_dir_in_i && !blk_out_ready_i;
      end
      if (state_q == BULK_IDLE) begin
        zdp_taken_q <= 1'b0;
      end else if (zdp_accepted_i) begin
        zdp_taken_q <= 1'b1;
      end
    end
  end

  // OUT stream steering, drain when not receiving
  always_comb begin
    case (state_q)
      BULK_DATO_RX: usb_tready_o = blk_tready_i;
      default:      usb_tready_o = 1'b1;
    endcase
  end

  assign blk_tvalid_o = (state_q == BULK_DATO_RX) && usb_tvalid_i;

  // IN side
  assign in_sel_o  = (state_q == BULK_DATI_TX);
  assign zdp_req_o = (state_q == BULK_IDLE) && bulk_go_i && bulk_dir_in_i && !blk_in_ready_i;

  // Handshake window covers reception and the reply
  assign out_phase_o = (state_q == BULK_DATO_RX) || (state_q == BULK_DATO_ERR) ||
                       (state_q == BULK_DATO_HSK);

  // Toggle only after an ACK either way
  assign toggle_out_o = (state_q == BULK_DATO_HSK) && hsk_sent_i && !out_nak_o;
  assign toggle_in_o  = (state_q == BULK_DATI_ACK) && hsk_recv_i && (hsk_type_i == HSK_ACK);

  assign bulk_done_o = (state_q == BULK_DONE);

endmodule

//--- verilog/handshake_issuer.sv
`timescale 1ns/1ps
module handshake_issuer
  import usb_xact_pkg::*;
#(
  parameter int EOP_DELAY = 5
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      usb_recv_i,
  input  logic      hsk_sent_i,
  input  logic      out_phase_i,
  input  logic      out_nak_i,
  output logic      hsk_send_o,
  output hsk_type_t hsk_type_o
);

  // Wide enough for a zero delay too
  localparam int CW = $clog2(EOP_DELAY + 2);

  logic [CW-1:0] eop_cnt_q;
  logic          eop_busy_q;
  // End-of-packet mark, one cycle
  logic          eop_q;

  // Count down from the received-packet pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      eop_busy_q <= 1'b0;
      eop_q      <= 1'b0;
    end else begin
      eop_q <= eop_busy_q && (eop_cnt_q == '0);
      if (usb_recv_i) begin
        eop_busy_q <= 1'b1;
      end else if (eop_cnt_q == '0) begin
        eop_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (usb_recv_i) begin
      eop_cnt_q <= CW'(EOP_DELAY);
    end else if (eop_busy_q && eop_cnt_q != '0) begin
      eop_cnt_q <= eop_cnt_q - 1'b1;
    end
  end

  // Request held until the encoder reports it sent
  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_send_o <= 1'b0;
    end else if (!hsk_send_o && eop_q && out_phase_i) begin
      hsk_send_o <= 1'b1;
    end else if (hsk_sent_i) begin
      hsk_send_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!hsk_send_o && eop_q) begin
      hsk_type_o <= out_nak_i ? HSK_NAK : HSK_ACK;
    end
  end

endmodule

//--- verilog/data_toggle.sv
`timescale 1ns/1ps
module data_toggle
  import usb_xact_pkg::*;
#(
  parameter int NUM_ENDPOINTS = 16
) (
  input  logic       clock,
  input  logic       reset,
  input  logic [3:0] endp_i,
  input  logic       toggle_out_i,
  input  logic       toggle_in_i,
  output data_pid_t  usb_pid_o
);

  // One DATA0/DATA1 bit per endpoint
  logic [NUM_ENDPOINTS-1:0] toggle_q;

  // Both pulses flip the same bit
  logic flip;

  assign flip = toggle_out_i || toggle_in_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      toggle_q <= '0;
    end else if (flip) begin
      toggle_q[endp_i] <= ~toggle_q[endp_i];
    end
  end

  // PID for the next data packet to the host
  assign usb_pid_o = toggle_q[endp_i] ? DATA1 : DATA0;

endmodule

//--- verilog/in_stream_mux.sv
`timescale 1ns/1ps
module in_stream_mux
  import usb_xact_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       in_sel_i,
  input  logic       zdp_req_i,
  input  logic       blk_tvalid_i,
  input  logic       blk_tlast_i,
  input  logic       blk_tkeep_i,
  input  logic [7:0] blk_tdata_i,
  input  logic       usb_tready_i,
  output logic       blk_tready_o,
  output logic       zdp_accepted_o,
  output logic       usb_tvalid_o,
  output logic       usb_tlast_o,
  output logic       usb_tkeep_o,
  output logic [7:0] usb_tdata_o
);

  // Pending zero-data beat
  logic zdp_q;

  assign zdp_accepted_o = zdp_q && !in_sel_i && usb_tready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      zdp_q <= 1'b0;
    end else if (zdp_req_i) begin
      zdp_q <= 1'b1;
    end else if (zdp_accepted_o) begin
      zdp_q <= 1'b0;
    end
  end

  // Bulk data passes straight through when selected
  assign blk_tready_o = in_sel_i && usb_tready_i;

  // Otherwise a single beat with no payload
  assign usb_tvalid_o = in_sel_i ? blk_tvalid_i : zdp_q;
  assign usb_tlast_o  = in_sel_i ? blk_tlast_i : zdp_q;
  assign usb_tkeep_o  = in_sel_i ? blk_tkeep_i : 1'b0;
  assign usb_tdata_o  = in_sel_i ? blk_tdata_i : 8'h00;

endmodule

//--- verilog/usb_transactor.sv
`timescale 1ns/1ps
module usb_transactor #(
  parameter logic [3:0] BULK_ENDPOINT = 4'd1,
  parameter int         EOP_DELAY     = 5,
  parameter int         NUM_ENDPOINTS = 16
) (
  input  logic                    clock,
  input  logic                    reset,
  // Configured device address
  input  logic [6:0]              usb_addr_i,
  // Decoder tokens and handshakes
  input  logic                    tok_recv_i,
  input  usb_xact_pkg::tok_type_t tok_type_i,
  input  logic [6:0]              tok_addr_i,
  input  logic [3:0]              tok_endp_i,
  input  logic                    hsk_recv_i,
  input  usb_xact_pkg::hsk_type_t hsk_type_i,
  input  logic                    usb_recv_i,
  // OUT bytes from the decoder
  input  logic                    usb_tvalid_i,
  output logic                    usb_tready_o,
  input  logic                    usb_tkeep_i,
  input  logic                    usb_tlast_i,
  input  logic [7:0]              usb_tdata_i,
  // IN bytes to the encoder
  output logic                    usb_tvalid_o,
  input  logic                    usb_tready_i,
  output logic                    usb_tkeep_o,
  output logic                    usb_tlast_o,
  output logic [7:0]              usb_tdata_o,
  output usb_xact_pkg::data_pid_t usb_pid_o,
  input  logic                    usb_sent_i,
  // Handshake request to the encoder
  output logic                    hsk_send_o,
  output usb_xact_pkg::hsk_type_t hsk_type_o,
  input  logic                    hsk_sent_i,
  // Bulk endpoint control
  input  logic                    blk_in_ready_i,
  input  logic                    blk_out_ready_i,
  output logic                    blk_start_o,
  output logic                    blk_cycle_o,
  output logic [3:0]              blk_endpt_o,
  // Bulk OUT stream
  output logic                    blk_tvalid_o,
  input  logic                    blk_tready_i,
  output logic                    blk_tlast_o,
  output logic                    blk_tkeep_o,
  output logic [7:0]              blk_tdata_o,
  // Bulk IN stream
  input  logic                    blk_tvalid_i,
  output logic                    blk_tready_o,
  input  logic                    blk_tlast_i,
  input  logic                    blk_tkeep_i,
  input  logic [7:0]              blk_tdata_i,
  // Reject reporting
  output usb_xact_pkg::err_code_t err_code_o,
  output logic                    xfer_error_o
);

  logic       bulk_go;
  logic       bulk_dir_in;
  logic [3:0] xfer_endp;
  logic       bulk_done;
  logic       out_phase;
  logic       out_nak;
  logic       zdp_req;
  logic       in_sel;
  logic       toggle_out;
  logic       toggle_in;
  logic       zdp_accepted;

  // OUT payload goes unchanged, only valid is steered
  assign blk_endpt_o = xfer_endp;
  assign blk_tlast_o = usb_tlast_i;
  assign blk_tkeep_o = usb_tkeep_i;
  assign blk_tdata_o = usb_tdata_i;

  token_dispatch #(
    .BULK_ENDPOINT(BULK_ENDPOINT)
  ) i_token_dispatch (
    .clock        (clock),
    .reset        (reset),
    .usb_addr_i   (usb_addr_i),
    .tok_recv_i   (tok_recv_i),
    .tok_type_i   (tok_type_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .bulk_done_i  (bulk_done),
    .bulk_go_o    (bulk_go),
    .bulk_dir_in_o(bulk_dir_in),
    .xfer_endp_o  (xfer_endp),
    .blk_cycle_o  (blk_cycle_o),
    .xfer_error_o (xfer_error_o),
    .err_code_o   (err_code_o)
  );

  bulk_sequencer i_bulk_sequencer (
    .clock          (clock),
    .reset          (reset),
    .bulk_go_i      (bulk_go),
    .bulk_dir_in_i  (bulk_dir_in),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .usb_sent_i     (usb_sent_i),
    .hsk_recv_i     (hsk_recv_i),
    .hsk_type_i     (hsk_type_i),
    .hsk_sent_i     (hsk_sent_i),
    .zdp_accepted_i (zdp_accepted),
    .usb_tvalid_i   (usb_tvalid_i),
    .usb_tlast_i    (usb_tlast_i),
    .blk_tready_i   (blk_tready_i),
    .bulk_done_o    (bulk_done),
    .blk_start_o    (blk_start_o),
    .usb_tready_o   (usb_tready_o),
    .blk_tvalid_o   (blk_tvalid_o),
    .in_sel_o       (in_sel),
    .zdp_req_o      (zdp_req),
    .out_phase_o    (out_phase),
    .out_nak_o      (out_nak),
    .toggle_out_o   (toggle_out),
    .toggle_in_o    (toggle_in)
  );

  handshake_issuer #(
    .EOP_DELAY(EOP_DELAY)
  ) i_handshake_issuer (
    .clock      (clock),
    .reset      (reset),
    .usb_recv_i (usb_recv_i),
    .hsk_sent_i (hsk_sent_i),
    .out_phase_i(out_phase),
    .out_nak_i  (out_nak),
    .hsk_send_o (hsk_send_o),
    .hsk_type_o (hsk_type_o)
  );

  data_toggle #(
    .NUM_ENDPOINTS(NUM_ENDPOINTS)
  ) i_data_toggle (
    .clock       (clock),
    .reset       (reset),
    .endp_i      (xfer_endp),
    .toggle_out_i(toggle_out),
    .toggle_in_i (toggle_in),
    .usb_pid_o   (usb_pid_o)
  );

  in_stream_mux i_in_stream_mux (
    .clock         (clock),
    .reset         (reset),
    .in_sel_i      (in_sel),
    .zdp_req_i     (zdp_req),
    .blk_tvalid_i  (blk_tvalid_i),
    .blk_tlast_i   (blk_tlast_i),
    .blk_tkeep_i   (blk_tkeep_i),
    .blk_tdata_i   (blk_tdata_i),
    .usb_tready_i  (usb_tready_i),
    .blk_tready_o  (blk_tready_o),
    .zdp_accepted_o(zdp_accepted),
    .usb_tvalid_o  (usb_tvalid_o),
    .usb_tlast_o   (usb_tlast_o),
    .usb_tkeep_o   (usb_tkeep_o),
    .usb_tdata_o   (usb_tdata_o)
  );

endmodule

//--- tb/usb_transactor_props.sv
`timescale 1ns/1ps
module usb_transactor_props (
  input logic clock,
  input logic reset,
  input logic hsk_send_i,
  input logic hsk_sent_i,
  input logic blk_start_i,
  input logic usb_tvalid_i,
  input logic out_phase_i
);

  // Handshake request stays up until the encoder has sent it
  hsk_hold: assert property (@(posedge clock) disable iff (reset)
    hsk_send_i && !hsk_sent_i |=> hsk_send_i)
    else $error("hsk_send_o dropped before hsk_sent_i");

  // And drops right after
  hsk_release: assert property (@(posedge clock) disable iff (reset)
    hsk_send_i && hsk_sent_i |=> !hsk_send_i)
    else $error("hsk_send_o still high after hsk_sent_i");

  // Nothing toward the encoder while OUT data is handled
  in_dir: assert property (@(posedge clock) disable iff (reset)
    usb_tvalid_i |-> !out_phase_i)
    else $error("usb_tvalid_o high during the OUT phase");

  start_pulse: assert property (@(posedge clock) disable iff (reset)
    blk_start_i |=> !blk_start_i)
    else $error("blk_start_o longer than one cycle");

endmodule

// Sequencer and handshake signals as seen at the top level
bind usb_transactor usb_transactor_props i_usb_transactor_props (
  .clock       (clock),
  .reset       (reset),
  .hsk_send_i  (hsk_send_o),
  .hsk_sent_i  (hsk_sent_i),
  .blk_start_i (blk_start_o),
  .usb_tvalid_i(usb_tvalid_o),
  .out_phase_i (out_phase)
);

//--- tb/tb_usb_transactor.sv
`timescale 1ns/1ps
module tb_usb_transactor
  import usb_xact_pkg::*;
();

  localparam logic [3:0] BULK_EP    = 4'd1;
  localparam int         EOP_DELAY  = 5;
  localparam logic [6:0] DEV_ADDR   = 7'h2a;
  // Six short tests of at most about 200 cycles each, with margin
  localparam int         MAX_CYCLES = 2000;

  logic       clock, reset;
  logic [6:0] usb_addr_i, tok_addr_i;
  logic [3:0] tok_endp_i, blk_endpt_o;
  tok_type_t  tok_type_i;
  hsk_type_t  hsk_type_i, hsk_type_o;
  data_pid_t  usb_pid_o;
  err_code_t  err_code_o;
  logic       tok_recv_i, hsk_recv_i, usb_recv_i, usb_sent_i, hsk_sent_i, hsk_send_o;
  logic       usb_tvalid_i, usb_tready_o, usb_tkeep_i, usb_tlast_i;
  logic       usb_tvalid_o, usb_tready_i, usb_tkeep_o, usb_tlast_o;
  logic [7:0] usb_tdata_i, usb_tdata_o, blk_tdata_o, blk_tdata_i;
  logic       blk_in_ready_i, blk_out_ready_i, blk_start_o, blk_cycle_o, xfer_error_o;
  logic       blk_tvalid_o, blk_tready_i, blk_tlast_o, blk_tkeep_o;
  logic       blk_tvalid_i, blk_tready_o, blk_tlast_i, blk_tkeep_i;

  // Expected beats, {last, keep, data} in both directions
  logic [9:0] exp_out_q [$];
  logic [9:0] exp_in_q [$];
  logic [9:0] out_beat;
  logic [9:0] in_beat;
  logic [7:0] payload [0:15];
  data_pid_t  exp_pid;
  // Extra rules for the drain and zero-data tests
  bit         drain_mode, zdp_mode;

  integer     seed;
  int         cycle_count, error_count, test_errors, tests_run, tests_failed;
  string      test_name;

  // Reference model state
  bit         model_toggle [0:15];
  err_code_t  model_err;

  usb_transactor #(
    .BULK_ENDPOINT(BULK_EP),
    .EOP_DELAY    (EOP_DELAY),
    .NUM_ENDPOINTS(16)
  ) i_usb_transactor (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Matching token sets a new code, others leave the held one
  function automatic err_code_t model_token(input tok_type_t ty, input logic [6:0] addr,
                                            input logic [3:0] ep);
    bit data_tok;
    data_tok = (ty == TOK_IN) || (ty == TOK_OUT);
    if (addr == DEV_ADDR) begin
      if (data_tok && ep == BULK_EP) begin
        model_err = (ty == TOK_IN) ? ERR_BLK_IN : ERR_BLK_OUT;
      end else begin
        model_err = data_tok ? ERR_ENDP : ERR_TOKEN;
      end
    end
    return model_err;
  endfunction

  function automatic data_pid_t model_pid(input logic [3:0] ep);
    return model_toggle[ep] ? DATA1 : DATA0;
  endfunction

  // Endpoint not ready means the OUT data is refused
  function automatic hsk_type_t model_hsk(input bit ready);
    return ready ? HSK_ACK : HSK_NAK;
  endfunction

  // Only an acknowledged packet advances the sequence bit
  function automatic void model_finish(input logic [3:0] ep, input bit acked);
    if (acked) begin
      model_toggle[ep] = ~model_toggle[ep];
    end
  endfunction

  function automatic void report_mismatch(input string what, input logic [31:0] exp,
                                          input logic [31:0] act);
    $display("MISMATCH %s %s: expected %0h actual %0h", test_name, what, exp, act);
    error_count++;
  endfunction

  function automatic void report_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    error_count++;
  endfunction

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (error_count != test_errors) begin
      tests_failed++;
    end
    $display("test %-14s %s, %0d errors", test_name,
             (error_count == test_errors) ? "ok" : "failed", error_count - test_errors);
  endtask

  // One-cycle token pulse, returns on the falling edge after it was taken
  task automatic send_token(input tok_type_t ty, input logic [6:0] addr, input logic [3:0] ep);
    @(negedge clock);
    tok_recv_i = 1'b1;
    tok_type_i = ty;
    tok_addr_i = addr;
    tok_endp_i = ep;
    @(negedge clock);
    tok_recv_i = 1'b0;
  endtask

  task automatic start_transfer(input tok_type_t ty);
    err_code_t exp_code;
    exp_code = model_token(ty, DEV_ADDR, BULK_EP);
    send_token(ty, DEV_ADDR, BULK_EP);
    // Cycle and start flags one cycle after the token
    @(negedge clock);
    if (blk_cycle_o !== 1'b1) report_mismatch("blk_cycle_o", 1, blk_cycle_o);
    if (blk_start_o !== 1'b1) report_mismatch("blk_start_o", 1, blk_start_o);
    if (blk_endpt_o !== BULK_EP) report_mismatch("blk_endpt_o", BULK_EP, blk_endpt_o);
    if (err_code_o !== exp_code) report_mismatch("err_code_o", exp_code, err_code_o);
    @(negedge clock);
    if (blk_start_o !== 1'b0) report_error("blk_start_o stayed high for a second cycle");
  endtask

  task automatic reject_token(input tok_type_t ty, input logic [6:0] addr, input logic [3:0] ep);
    err_code_t exp_code;
    bit        exp_err;
    exp_code = model_token(ty, addr, ep);
    exp_err  = (addr == DEV_ADDR);
    send_token(ty, addr, ep);
    @(negedge clock);
    if (xfer_error_o !== exp_err) report_mismatch("xfer_error_o", exp_err, xfer_error_o);
    if (err_code_o !== exp_code) report_mismatch("err_code_o", exp_code, err_code_o);
    if (blk_cycle_o !== 1'b0) report_error("blk_cycle_o rose for a rejected token");
    @(negedge clock);
    if (xfer_error_o !== 1'b0) report_error("xfer_error_o lasted more than one cycle");
    if (err_code_o !== exp_code) report_mismatch("err_code_o held", exp_code, err_code_o);
  endtask

  task automatic wait_idle();
    while (blk_cycle_o) begin
      @(negedge clock);
    end
  endtask

  task automatic run_out(input int n, input bit ready);
    int        idx;
    int        delay;
    hsk_type_t exp_hsk;
    blk_out_ready_i = ready;
    drain_mode      = !ready;
    exp_hsk         = model_hsk(ready);
    for (int i = 0; i < n; i++) begin
      payload[i] = 8'($random(seed));
      if (ready) exp_out_q.push_back({i == n - 1, 1'b1, payload[i]});
    end
    start_transfer(TOK_OUT);
    idx = 0;
    while (idx < n) begin
      @(negedge clock);
      usb_tvalid_i = 1'b1;
      usb_tkeep_i  = 1'b1;
      usb_tdata_i  = payload[idx];
      usb_tlast_i  = (idx == n - 1);
      blk_tready_i = ($random(seed) & 3) != 0;
      #1;
      if (usb_tready_o) idx++;
      @(posedge clock);
    end
    // Packet end from the decoder
    @(negedge clock);
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
    blk_tready_i = 1'b1;
    usb_recv_i   = 1'b1;
    @(negedge clock);
    usb_recv_i = 1'b0;
    delay      = 0;
    while (!hsk_send_o && delay < 4 * EOP_DELAY + 8) begin
      @(negedge clock);
      delay++;
    end
    if (delay != EOP_DELAY + 2) report_mismatch("handshake delay", EOP_DELAY + 2, delay);
    if (hsk_type_o !== exp_hsk) report_mismatch("hsk_type_o", exp_hsk, hsk_type_o);
    @(negedge clock);
    hsk_sent_i = 1'b1;
    @(negedge clock);
    hsk_sent_i = 1'b0;
    if (hsk_send_o !== 1'b0) report_error("hsk_send_o stayed high after hsk_sent_i");
    model_finish(BULK_EP, exp_hsk == HSK_ACK);
    wait_idle();
    if (exp_out_q.size() != 0) report_error("OUT bytes never reached the endpoint");
    drain_mode = 1'b0;
  endtask

  task automatic run_in(input int n, input bit ready, input hsk_type_t host_hsk);
    int idx;
    bit done;
    blk_in_ready_i = ready;
    zdp_mode       = !ready;
    exp_pid        = model_pid(BULK_EP);
    if (ready) begin
      for (int i = 0; i < n; i++) begin
        payload[i] = 8'($random(seed));
        exp_in_q.push_back({i == n - 1, 1'b1, payload[i]});
      end
    end else begin
      // Zero-data packet, last set and no payload
      exp_in_q.push_back({1'b1, 1'b0, 8'h00});
    end
    // Encoder stalled so no beat leaves before the loop below watches
    usb_tready_i = 1'b0;
    start_transfer(TOK_IN);
    idx  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      usb_tready_i = ($random(seed) & 3) != 0;
      blk_tvalid_i = ready && idx < n;
      blk_tkeep_i  = 1'b1;
      if (idx < n) begin
        blk_tdata_i = payload[idx];
        blk_tlast_i = (idx == n - 1);
      end
      #1;
      if (blk_tvalid_i && blk_tready_o) idx++;
      if (usb_tvalid_o && usb_tready_i && usb_tlast_o) done = 1'b1;
      @(posedge clock);
    end
    // Encoder reports the packet out, then the host answers
    @(negedge clock);
    blk_tvalid_i = 1'b0;
    blk_tlast_i  = 1'b0;
    usb_tready_i = 1'b1;
    usb_sent_i   = 1'b1;
    @(negedge clock);
    usb_sent_i = 1'b0;
    hsk_recv_i = 1'b1;
    hsk_type_i = host_hsk;
    @(negedge clock);
    hsk_recv_i = 1'b0;
    model_finish(BULK_EP, host_hsk == HSK_ACK);
    wait_idle();
    if (exp_in_q.size() != 0) report_error("IN beats never reached the encoder");
    zdp_mode = 1'b0;
  endtask

  // Compare every stream beat with the expected queues
  always @(posedge clock) begin
    if (!reset) begin
      if (blk_tvalid_o && blk_tready_i) begin
        if (exp_out_q.size() == 0) begin
          report_error("endpoint got an OUT byte that was not expected");
        end else begin
          out_beat = exp_out_q.pop_front();
          if (blk_tdata_o !== out_beat[7:0]) begin
            report_mismatch("blk_tdata_o", out_beat[7:0], blk_tdata_o);
          end
          if (blk_tkeep_o !== out_beat[8]) report_mismatch("blk_tkeep_o", out_beat[8], blk_tkeep_o);
          if (blk_tlast_o !== out_beat[9]) report_mismatch("blk_tlast_o", out_beat[9], blk_tlast_o);
        end
      end
      if (drain_mode && blk_tvalid_o) report_error("blk_tvalid_o rose with the endpoint not ready");
      if (usb_tvalid_o && usb_tready_i) begin
        if (exp_in_q.size() == 0) begin
          report_error("encoder got an IN beat that was not expected");
        end else begin
          in_beat = exp_in_q.pop_front();
          if (usb_tdata_o !== in_beat[7:0]) report_mismatch("usb_tdata_o", in_beat[7:0], usb_tdata_o);
          if (usb_tkeep_o !== in_beat[8]) report_mismatch("usb_tkeep_o", in_beat[8], usb_tkeep_o);
          if (usb_tlast_o !== in_beat[9]) report_mismatch("usb_tlast_o", in_beat[9], usb_tlast_o);
          if (usb_pid_o !== exp_pid) report_mismatch("usb_pid_o", exp_pid, usb_pid_o);
        end
      end
      if (zdp_mode && blk_tready_o) report_error("blk_tready_o rose during a zero-data packet");
    end
  end

  // Watchdog
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    seed            = 32'h4cb5;
    cycle_count     = 0;
    error_count     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    model_err       = ERR_NONE;
    drain_mode      = 1'b0;
    zdp_mode        = 1'b0;
    exp_pid         = DATA0;
    reset           = 1'b1;
    usb_addr_i      = DEV_ADDR;
    tok_recv_i      = 1'b0;
    tok_type_i      = TOK_OUT;
    tok_addr_i      = '0;
    tok_endp_i      = '0;
    hsk_recv_i      = 1'b0;
    hsk_type_i      = HSK_ACK;
    usb_recv_i      = 1'b0;
    usb_sent_i      = 1'b0;
    hsk_sent_i      = 1'b0;
    usb_tvalid_i    = 1'b0;
    usb_tkeep_i     = 1'b0;
    usb_tlast_i     = 1'b0;
    usb_tdata_i     = '0;
    usb_tready_i    = 1'b1;
    blk_in_ready_i  = 1'b1;
    blk_out_ready_i = 1'b1;
    blk_tready_i    = 1'b1;
    blk_tvalid_i    = 1'b0;
    blk_tlast_i     = 1'b0;
    blk_tkeep_i     = 1'b0;
    blk_tdata_i     = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    begin_test("reset_values");
    if (hsk_send_o !== 1'b0) report_mismatch("hsk_send_o", 0, hsk_send_o);
    if (blk_cycle_o !== 1'b0) report_mismatch("blk_cycle_o", 0, blk_cycle_o);
    if (blk_start_o !== 1'b0) report_mismatch("blk_start_o", 0, blk_start_o);
    if (usb_tvalid_o !== 1'b0) report_mismatch("usb_tvalid_o", 0, usb_tvalid_o);
    if (blk_tvalid_o !== 1'b0) report_mismatch("blk_tvalid_o", 0, blk_tvalid_o);
    if (xfer_error_o !== 1'b0) report_mismatch("xfer_error_o", 0, xfer_error_o);
    if (err_code_o !== ERR_NONE) report_mismatch("err_code_o", ERR_NONE, err_code_o);
    if (usb_pid_o !== DATA0) report_mismatch("usb_pid_o", DATA0, usb_pid_o);
    end_test();

    begin_test("bulk_out");
    run_out(8, 1'b1);
    end_test();

    // ACK, NAK, ACK shows the PID sequence both ways
    begin_test("bulk_in");
    run_in(8, 1'b1, HSK_ACK);
    run_in(5, 1'b1, HSK_NAK);
    run_in(6, 1'b1, HSK_ACK);
    end_test();

    begin_test("in_zero_data");
    run_in(0, 1'b0, HSK_ACK);
    end_test();

    begin_test("out_nak_drain");
    run_out(6, 1'b0);
    run_in(4, 1'b1, HSK_ACK);
    end_test();

    begin_test("token_reject");
    reject_token(TOK_OUT, DEV_ADDR ^ 7'h01, BULK_EP);
    reject_token(TOK_IN, DEV_ADDR, 4'd3);
    reject_token(TOK_SETUP, DEV_ADDR, BULK_EP);
    run_out(4, 1'b1);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- flist.f
verilog/usb_xact_pkg.sv
verilog/token_dispatch.sv
verilog/bulk_sequencer.sv
verilog/handshake_issuer.sv
verilog/data_toggle.sv
verilog/in_stream_mux.sv
verilog/usb_transactor.sv
tb/usb_transactor_props.sv
tb/tb_usb_transactor.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f flist.f --top-module tb_usb_transactor -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
